//--- project.f
verilog/wback_cfg_pkg.sv
verilog/wback_bus_pkg.sv
verilog/wback_fsm.sv
verilog/wback_lane_counter.sv
verilog/wback_addr_gen.sv
verilog/wback_top.sv
bench/wback_tb.sv

//--- bench/wback_tests.txt
// layer plane rdata_addr comps_addr ps_addr items fin_item delay writes
// fin_item ff marks no item with final outputs, delay 1 gives random ready delays
0 0010 00001000 00002000 00003000 2 ff 0 6
0 0015 00001000 00004001 00005000 1 0 0 3
0 0040 00001000 00006002 00007000 4 3 1 c
2 0010 00008003 00000000 00000000 3 ff 0 3
2 0008 00009000 00000000 00000000 4 1 1 4
0 0103 00000000 0000a000 0000b000 3 1 1 9
0 ffff 00000000 00000000 fffffff0 2 ff 1 6
2 0001 0000c001 00000000 00000000 2 0 1 2
0 0007 00000000 0000d003 0000e006 5 2 1 f
0 0002 00000000 00010000 00020000 1 ff 1 3
2 0020 0000f002 00000000 00000000 1 ff 0 1
0 0009 00000000 00030001 00040002 2 1 0 6

//--- bench/wback_tb.sv
module wback_tb
    import wback_cfg_pkg::*, wback_bus_pkg::*;
();

    localparam int PLANE_W   = 16;
    localparam int FIELDS    = 9;
    localparam int MAX_TESTS = 32;
    localparam int MAX_WORDS = FIELDS * MAX_TESTS;

    logic                 clk;
    logic                 resetn;
    layer_type_e          cfg_layer;
    logic [PLANE_W-1:0]   plane_size;
    stage_status_t        rdata;
    stage_status_t        comps;
    logic [ADDR_W-1:0]    ps_addr;
    logic [NUM_LANES-1:0] quant_rdy;
    logic                 mem_ready;
    mem_wr_t              mem;
    logic [NUM_LANES-1:0] quant_enb;
    logic [NUM_LANES-1:0] obuf_enb;
    logic [NUM_LANES-1:0] obuf_ld_wrn;
    logic                 start;
    logic                 rdy;
    logic                 fin;

    // Nine words per test, see the data file for the columns
    logic [31:0] tests [0:MAX_WORDS-1];

    logic [31:0] t_layer;
    logic [31:0] t_plane;
    logic [31:0] t_rd;
    logic [31:0] t_cp;
    logic [31:0] t_ps;
    logic [31:0] t_items;
    logic [31:0] t_fin_item;
    logic [31:0] t_delay;
    logic [31:0] t_writes;

    integer seed;
    int     errors;
    int     checks;
    int     cycles = 0;
    int     cycle_limit;

    wback_top #(
        .PLANE_W (PLANE_W)
    ) u_dut (
        .clk               (clk),
        .resetn            (resetn),
        .i_cfg_layer       (cfg_layer),
        .i_plane_size      (plane_size),
        .i_rdata           (rdata),
        .i_comps           (comps),
        .i_comps_ps_addr   (ps_addr),
        .i_quant_rdy       (quant_rdy),
        .i_mem_write_ready (mem_ready),
        .o_mem             (mem),
        .o_quant_enb       (quant_enb),
        .o_obuf_enb        (obuf_enb),
        .o_obuf_ld_wrn     (obuf_ld_wrn),
        .o_start           (start),
        .o_rdy             (rdy),
        .o_fin             (fin)
    );

    initial clk = 1'b0;

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT never reached finish", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // Lane address of one write, from the layer rules
    function automatic logic [ADDR_W-1:0] expect_addr(input logic pool, input logic final_o,
                                                      input int item, input int lane);
        logic [ADDR_W-1:0] step;
        step = lane * t_plane;
        if (pool) begin
            return t_rd + item;
        end else if (final_o) begin
            return t_cp + item + step;
        end
        // Partial sums step in words
        return t_ps + 4 * item + (step << 2);
    endfunction

    function automatic logic [STRB_W-1:0] expect_strb(input logic byte_wr,
                                                      input logic [ADDR_W-1:0] addr);
        if (byte_wr) begin
            return STRB_W'(1) << addr[1:0];
        end
        return '1;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h exp %h at %0t", name, got, exp, $time);
        end
    endtask

    // Upstream status for one item
    task automatic present_item(input int item);
        logic fin_here;
        fin_here         = (item == t_fin_item);
        rdata.addr       = t_rd + item;
        comps.addr       = t_cp + item;
        ps_addr          = t_ps + 4 * item;
        // The stage that the layer ignores reports the opposite flag
        rdata.is_out_fin = (t_layer == 32'd2) ? fin_here : !fin_here;
        comps.is_out_fin = (t_layer == 32'd2) ? !fin_here : fin_here;
    endtask

    task automatic run_test(input int idx);
        int                item;
        int                lane;
        int                lanes_item;
        int                writes;
        int                mem_left;
        int                quant_left;
        logic              pool;
        logic              cur_final;
        logic              mem_pending;
        logic              quant_pending;
        logic              quant_wait;
        logic              quant_done;
        logic              hold_wr;
        logic              fin_seen;
        mem_wr_t           held;
        logic [ADDR_W-1:0] e_addr;

        t_layer    = tests[idx * FIELDS];
        t_plane    = tests[idx * FIELDS + 1];
        t_rd       = tests[idx * FIELDS + 2];
        t_cp       = tests[idx * FIELDS + 3];
        t_ps       = tests[idx * FIELDS + 4];
        t_items    = tests[idx * FIELDS + 5];
        t_fin_item = tests[idx * FIELDS + 6];
        t_delay    = tests[idx * FIELDS + 7];
        t_writes   = tests[idx * FIELDS + 8];
        pool       = (t_layer == 32'd2);
        lanes_item = pool ? 1 : NUM_LANES;
        $display("Test %0d: layer %0d, %0d items, delay mode %0d", idx, t_layer, t_items,
                 t_delay);

        @(posedge clk);
        #1;
        resetn     = 1'b0;
        cfg_layer  = layer_type_e'(t_layer[3:0]);
        plane_size = t_plane[PLANE_W-1:0];
        rdata.rdy  = 1'b1;
        rdata.fin  = 1'b0;
        comps.rdy  = 1'b1;
        comps.fin  = 1'b0;
        quant_rdy  = '0;
        mem_ready  = (t_delay == 0);
        present_item(0);
        repeat (4) @(posedge clk);
        #1;
        check_val("o_start", start, 1);
        check_val("o_quant_enb", quant_enb, 0);
        check_val("o_obuf_enb", obuf_enb, 0);
        check_val("o_obuf_ld_wrn", obuf_ld_wrn, 0);
        check_val("o_mem.wenb", mem.wenb, 0);
        check_val("o_rdy", rdy, 0);
        check_val("o_fin", fin, 0);
        resetn = 1'b1;

        item          = 0;
        lane          = 0;
        writes        = 0;
        mem_left      = 0;
        quant_left    = 0;
        mem_pending   = 1'b0;
        quant_pending = 1'b0;
        quant_wait    = 1'b0;
        quant_done    = 1'b0;
        hold_wr       = 1'b0;
        fin_seen      = 1'b0;
        while (!fin_seen) begin
            @(negedge clk);
            cur_final = !pool && (item == t_fin_item);
            if (mem.wenb != 0) begin
                e_addr = expect_addr(pool, cur_final, item, lane);
                check_val("o_mem.wenb", mem.wenb, 1 << lane);
                check_val("o_mem.waddr", mem.waddr, e_addr);
                check_val("o_mem.wstrb", mem.wstrb, expect_strb(pool | cur_final, e_addr));
                if (hold_wr) begin
                    check_val("held o_mem.waddr", mem.waddr, held.waddr);
                    check_val("held o_mem.wstrb", mem.wstrb, held.wstrb);
                end
                if (mem_ready) begin
                    writes++;
                    mem_pending = 1'b0;
                    hold_wr     = 1'b0;
                    lane        = (lane + 1) % lanes_item;
                end else begin
                    hold_wr = 1'b1;
                    held    = mem;
                end
            end else if (hold_wr) begin
                errors++;
                $display("Write enable dropped before the memory accepted it at %0t", $time);
                hold_wr = 1'b0;
            end
            if (pool) begin
                check_val("o_quant_enb", quant_enb, 0);
            end
            if (quant_wait) begin
                check_val("o_quant_enb", quant_enb, 3'b111);
            end
            if (quant_done) begin
                check_val("o_obuf_enb", obuf_enb, 3'b111);
            end
            quant_wait = 1'b0;
            quant_done = 1'b0;
            if (quant_enb != 0) begin
                checks++;
                if (!cur_final) begin
                    errors++;
                    $display("Quantizer enabled for an item without final outputs at %0t",
                             $time);
                end
                check_val("o_quant_enb", quant_enb, 3'b111);
                if (quant_rdy != 0) begin
                    quant_done    = 1'b1;
                    quant_pending = 1'b0;
                end else begin
                    quant_wait = 1'b1;
                end
            end
            if (obuf_enb != 0) begin
                check_val("o_obuf_enb", obuf_enb, pool ? 3'b001 : 3'b111);
            end
            check_val("o_obuf_ld_wrn", obuf_ld_wrn, obuf_enb);
            if (rdy) begin
                check_val("writes at o_rdy", writes, item * lanes_item);
            end
            if (fin) begin
                fin_seen = 1'b1;
            end

            @(posedge clk);
            #1;
            // Next item is presented while the DUT waits
            if (rdy) begin
                item++;
                if (item >= t_items) begin
                    // Only the stage that the layer waits on reports finish
                    rdata.fin = pool;
                    comps.fin = !pool;
                end else begin
                    present_item(item);
                end
            end
            if (quant_enb != 0) begin
                if (!quant_pending) begin
                    quant_pending = 1'b1;
                    quant_left    = (t_delay != 0) ? ($random(seed) & 3) : 0;
                end
                if (quant_left == 0) begin
                    quant_rdy = NUM_LANES'(1) << (item % NUM_LANES);
                end else begin
                    quant_rdy = '0;
                    quant_left--;
                end
            end else begin
                quant_rdy = '0;
            end
            if (t_delay == 0) begin
                mem_ready = 1'b1;
            end else if (mem.wenb != 0) begin
                if (!mem_pending) begin
                    mem_pending = 1'b1;
                    mem_left    = $random(seed) & 3;
                end
                if (mem_left == 0) begin
                    mem_ready = 1'b1;
                end else begin
                    mem_ready = 1'b0;
                    mem_left--;
                end
            end else begin
                mem_ready = 1'b0;
            end
        end

        repeat (6) begin
            @(negedge clk);
            check_val("o_fin", fin, 1);
            check_val("o_mem.wenb", mem.wenb, 0);
        end
        check_val("write count", writes, t_writes);
        check_val("item count", item, t_items);
    endtask

    initial begin
        int i;
        int total_items;
        int num_tests;

        seed        = 32'h7dcd;
        errors      = 0;
        checks      = 0;
        cycle_limit = 32'h7fff_ffff;
        resetn      = 1'b0;
        cfg_layer   = CONV;
        plane_size  = '0;
        rdata       = '0;
        comps       = '0;
        ps_addr     = '0;
        quant_rdy   = '0;
        mem_ready   = 1'b0;

        for (i = 0; i < MAX_WORDS; i++) begin
            tests[i] = '1;
        end
        $readmemh("bench/wback_tests.txt", tests);
        total_items = 0;
        num_tests   = 0;
        while (num_tests < MAX_TESTS && tests[num_tests * FIELDS] != 32'hffff_ffff) begin
            total_items += tests[num_tests * FIELDS + 5];
            num_tests++;
        end
        cycle_limit = 40 * total_items + 16 * num_tests;
        if (num_tests == 0) begin
            errors++;
            $display("No tests found in bench/wback_tests.txt");
        end

        for (i = 0; i < num_tests; i++) begin
            run_test(i);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/wback_top.sv
module wback_top
    import wback_cfg_pkg::*, wback_bus_pkg::*;
#(
    parameter int PLANE_W = 16
) (
    input  logic                 clk,
    input  logic                 resetn,
    input  layer_type_e          i_cfg_layer,
    // Output width times output height
    input  logic [PLANE_W-1:0]   i_plane_size,
    input  stage_status_t        i_rdata,
    input  stage_status_t        i_comps,
    input  logic [ADDR_W-1:0]    i_comps_ps_addr,
    input  logic [NUM_LANES-1:0] i_quant_rdy,
    input  logic                 i_mem_write_ready,
    output mem_wr_t              o_mem,
    output logic [NUM_LANES-1:0] o_quant_enb,
    output logic [NUM_LANES-1:0] o_obuf_enb,
    output logic [NUM_LANES-1:0] o_obuf_ld_wrn,
    output logic                 o_start,
    output logic                 o_rdy,
    output logic                 o_fin
);

    lane_ctl_t         ctl;
    logic [LANE_W-1:0] lane;
    logic              wr_phase;
    logic              lanes_done;

    wback_fsm u_fsm (
        .clk           (clk),
        .resetn        (resetn),
        .i_cfg_layer   (i_cfg_layer),
        .i_rdata       (i_rdata),
        .i_comps       (i_comps),
        .i_quant_rdy   (i_quant_rdy),
        .i_lanes_done  (lanes_done),
        .o_ctl         (ctl),
        .o_quant_enb   (o_quant_enb),
        .o_obuf_enb    (o_obuf_enb),
        .o_obuf_ld_wrn (o_obuf_ld_wrn),
        .o_start       (o_start),
        .o_rdy         (o_rdy),
        .o_fin         (o_fin)
    );

    wback_lane_counter u_lane_counter (
        .clk               (clk),
        .resetn            (resetn),
        .i_ctl             (ctl),
        .i_mem_write_ready (i_mem_write_ready),
        .o_lane            (lane),
        .o_wr_phase        (wr_phase),
        .o_lanes_done      (lanes_done)
    );

    wback_addr_gen #(
        .PLANE_W (PLANE_W)
    ) u_addr_gen (
        .i_ctl        (ctl),
        .i_lane       (lane),
        .i_wr_phase   (wr_phase),
        .i_rdata_addr (i_rdata.addr),
        .i_comps_addr (i_comps.addr),
        .i_ps_addr    (i_comps_ps_addr),
        .i_plane_size (i_plane_size),
        .o_mem        (o_mem)
    );

endmodule

//--- verilog/wback_addr_gen.sv
module wback_addr_gen
    import wback_cfg_pkg::*, wback_bus_pkg::*;
#(
    parameter int PLANE_W = 16
) (
    input  lane_ctl_t          i_ctl,
    input  logic [LANE_W-1:0]  i_lane,
    input  logic               i_wr_phase,
    input  logic [ADDR_W-1:0]  i_rdata_addr,
    input  logic [ADDR_W-1:0]  i_comps_addr,
    input  logic [ADDR_W-1:0]  i_ps_addr,
    input  logic [PLANE_W-1:0] i_plane_size,
    output mem_wr_t            o_mem
);

    logic [ADDR_W-1:0] lane_off;
    logic [ADDR_W-1:0] out_base;
    logic [ADDR_W-1:0] out_addr;
    logic [ADDR_W-1:0] ps_addr;
    logic              use_out;

    // One output plane per lane
    assign lane_off = ADDR_W'(i_lane) * ADDR_W'(i_plane_size);

    assign out_base = i_ctl.single_lane ? i_rdata_addr : i_comps_addr;
    assign out_addr = out_base + lane_off;

    // Partial sums step in words, byte offset kept
    assign ps_addr = {i_ps_addr[ADDR_W-1:2] + lane_off[ADDR_W-3:0], i_ps_addr[1:0]};

    // Pooling always writes quantized bytes at the read address
    assign use_out = i_ctl.final_out | i_ctl.single_lane;

    always_comb begin
        o_mem.waddr = '0;
        o_mem.wstrb = '0;
        o_mem.wenb  = '0;
        if (i_ctl.wr_active) begin
            if (use_out) begin
                o_mem.waddr = out_addr;
                o_mem.wstrb = STRB_W'(1) << out_addr[1:0];
            end else begin
                o_mem.waddr = ps_addr;
                o_mem.wstrb = '1;
            end
            if (i_wr_phase) begin
                o_mem.wenb = NUM_LANES'(1) << i_lane;
            end
        end
    end

    // Only one lane may drive the shared address at a time
    always_comb begin
        a_wenb_onehot: assert #0 ($onehot0(o_mem.wenb))
            else $error("wenb not one-hot: %b", o_mem.wenb);
    end

endmodule

//--- verilog/wback_lane_counter.sv
module wback_lane_counter
    import wback_cfg_pkg::*, wback_bus_pkg::*;
(
    input  logic              clk,
    input  logic              resetn,
    input  lane_ctl_t         i_ctl,
    input  logic              i_mem_write_ready,
    output logic [LANE_W-1:0] o_lane,
    output logic              o_wr_phase,
    output logic              o_lanes_done
);

    logic last_lane;
    logic accept;

    assign last_lane = i_ctl.single_lane ? (o_lane == '0)
                                         : (o_lane == LANE_W'(NUM_LANES - 1));

    // Write accepted when the enable phase meets ready
    assign accept = i_ctl.wr_active & o_wr_phase & i_mem_write_ready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            o_lane     <= '0;
            o_wr_phase <= 1'b0;
        end else if (!i_ctl.wr_active) begin
            o_lane     <= '0;
            o_wr_phase <= 1'b0;
        end else if (!o_wr_phase) begin
            // Setup cycle done, raise the enable next
            o_wr_phase <= 1'b1;
        end else if (accept) begin
            o_wr_phase <= 1'b0;
            o_lane     <= last_lane ? '0 : o_lane + 1'b1;
        end
    end

    assign o_lanes_done = accept & last_lane;

    a_lane_range: assert property (@(posedge clk) disable iff (!resetn)
        o_lane < LANE_W'(NUM_LANES));

    a_done_on_ready: assert property (@(posedge clk) disable iff (!resetn)
        o_lanes_done |-> i_mem_write_ready);

endmodule

//--- verilog/wback_fsm.sv
module wback_fsm
    import wback_cfg_pkg::*, wback_bus_pkg::*;
(
    input  logic                 clk,
    input  logic                 resetn,
    input  layer_type_e          i_cfg_layer,
    input  stage_status_t        i_rdata,
    input  stage_status_t        i_comps,
    input  logic [NUM_LANES-1:0] i_quant_rdy,
    input  logic                 i_lanes_done,
    output lane_ctl_t            o_ctl,
    output logic [NUM_LANES-1:0] o_quant_enb,
    output logic [NUM_LANES-1:0] o_obuf_enb,
    output logic [NUM_LANES-1:0] o_obuf_ld_wrn,
    output logic                 o_start,
    output logic                 o_rdy,
    output logic                 o_fin
);

    wback_state_e state;
    wback_state_e state_nxt;

    logic is_pool;
    logic rdata_go;
    logic comps_go;
    logic up_go;
    logic final_out;
    logic layer_fin;
    logic [NUM_LANES-1:0] load_mask;

    assign is_pool  = (i_cfg_layer == POOL);
    assign rdata_go = i_rdata.rdy | i_rdata.fin;
    assign comps_go = i_comps.rdy | i_comps.fin;

    // Pooling has no compute stage to wait on
    assign up_go = is_pool ? rdata_go : (rdata_go & comps_go);

    assign final_out = is_pool ? i_rdata.is_out_fin : i_comps.is_out_fin;
    assign layer_fin = is_pool ? i_rdata.fin : i_comps.fin;

    // Pooling loads only the first output buffer
    assign load_mask = is_pool ? NUM_LANES'(1) : '1;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= S_START;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            S_START: begin
                if (up_go) begin
                    state_nxt = is_pool ? S_LOAD : S_QUANT_OR_LOAD;
                end
            end
            S_QUANT_OR_LOAD: begin
                if (!final_out) begin
                    state_nxt = S_WRITE;
                end else if (|i_quant_rdy) begin
                    state_nxt = S_LOAD;
                end
            end
            S_LOAD: begin
                state_nxt = S_WRITE;
            end
            S_WRITE: begin
                if (i_lanes_done) begin
                    state_nxt = S_WAIT;
                end
            end
            S_WAIT: begin
                if (up_go) begin
                    if (layer_fin) begin
                        state_nxt = S_FINISH;
                    end else begin
                        state_nxt = is_pool ? S_LOAD : S_QUANT_OR_LOAD;
                    end
                end
            end
            default: begin
                state_nxt = S_FINISH;
            end
        endcase
    end

    always_comb begin
        o_quant_enb   = '0;
        o_obuf_enb    = '0;
        o_obuf_ld_wrn = '0;
        case (state)
            S_QUANT_OR_LOAD: begin
                if (final_out) begin
                    o_quant_enb = '1;
                end else begin
                    // Partial sums are read straight out of the buffers
                    o_obuf_enb    = '1;
                    o_obuf_ld_wrn = '1;
                end
            end
            S_LOAD: begin
                o_obuf_enb    = load_mask;
                o_obuf_ld_wrn = load_mask;
            end
            default: begin
                o_quant_enb = '0;
            end
        endcase
    end

    assign o_start = (state == S_START);
    assign o_rdy   = (state == S_WAIT);
    assign o_fin   = (state == S_FINISH);

    assign o_ctl.wr_active   = (state == S_WRITE);
    assign o_ctl.final_out   = final_out;
    assign o_ctl.single_lane = is_pool;

    // Finish is terminal until reset
    a_finish_sticky: assert property (@(posedge clk) disable iff (!resetn)
        state == S_FINISH |=> state == S_FINISH);

    a_pool_no_quant: assert property (@(posedge clk) disable iff (!resetn)
        is_pool |-> o_quant_enb == '0);

endmodule

//--- verilog/wback_bus_pkg.sv
package wback_bus_pkg;

    import wback_cfg_pkg::*;

    // Level status reported by one upstream stage
    typedef struct packed {
        logic              rdy;
        logic              fin;
        logic              is_out_fin;
        logic [ADDR_W-1:0] addr;
    } stage_status_t;

    // Write control from the FSM to the counter and address generator
    typedef struct packed {
        // FSM sits in S_WRITE
        logic wr_active;
        // Selected out-finished flag
        logic final_out;
        // Pooling, lane 0 only
        logic single_lane;
    } lane_ctl_t;

    // Memory write port, enable held until ready
    typedef struct packed {
        logic [ADDR_W-1:0]    waddr;
        logic [STRB_W-1:0]    wstrb;
        logic [NUM_LANES-1:0] wenb;
    } mem_wr_t;

endpackage

//--- verilog/wback_cfg_pkg.sv
package wback_cfg_pkg;

    // Layer encodings as seen on the configuration port
    typedef enum logic [3:0] {
        CONV = 4'd0,
        POOL = 4'd2
    } layer_type_e;

    typedef enum logic [2:0] {
        S_START         = 3'd0,
        S_QUANT_OR_LOAD = 3'd1,
        S_LOAD          = 3'd2,
        S_WRITE         = 3'd3,
        S_WAIT          = 3'd4,
        S_FINISH        = 3'd5
    } wback_state_e;

    // Output-channel lanes written per item
    localparam int NUM_LANES = 3;

    // Lane index width
    localparam int LANE_W = $clog2(NUM_LANES);

    localparam int ADDR_W = 32;

    // Byte strobes per memory word
    localparam int STRB_W = 4;

endpackage
